// ==== sources.f ====
+incdir+test
hw/mipsPkg.sv
hw/alu.sv
hw/registerFile.sv
hw/controlUnit.sv
hw/datapath.sv
hw/mipsCore.sv
test/mipsCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the mipsCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mipsCoreTb -f sources.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/VmipsCoreTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qxF '*** PASSED ***'; then
	exit 0
fi
exit 1

// ==== test/isaModel.svh ====
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

logic [31:0] rngState = 32'h187e_3dfd;

// Linear congruential generator shared by program and delay generation
function automatic logic [31:0] lcgNext();
	rngState = rngState * 32'd1664525 + 32'd1013904223;
	return rngState;
endfunction

logic [31:0] modelRegs [32];
logic [31:0] modelMem [128];

// Expected events in program order
bit expKind [$]; // 0 register write, 1 store
logic [31:0] expAddr [$];
logic [31:0] expData [$];
string expName [$];

function automatic void expectEvent(bit kind, logic [31:0] a, logic [31:0] d, string name);
	expKind.push_back(kind);
	expAddr.push_back(a);
	expData.push_back(d);
	expName.push_back(name);
endfunction

// Mnemonic shown in error lines
function automatic string mnemonic(logic [31:0] ins);
	string name;
	name = "nop";
	if (ins[31:26] == 6'h00) begin
		case (ins[5:0])
			6'h00: name = "sll";
			6'h02: name = "srl";
			6'h03: name = "sra";
			6'h04: name = "sllv";
			6'h06: name = "srlv";
			6'h07: name = "srav";
			6'h20: name = "add";
			6'h21: name = "addu";
			6'h22: name = "sub";
			6'h23: name = "subu";
			6'h24: name = "and";
			6'h25: name = "or";
			6'h26: name = "xor";
			6'h27: name = "nor";
			6'h2a: name = "slt";
			6'h2b: name = "sltu";
			default: name = "nop";
		endcase
	end else begin
		case (ins[31:26])
			6'h08: name = "addi";
			6'h09: name = "addiu";
			6'h0a: name = "slti";
			6'h0b: name = "sltiu";
			6'h0c: name = "andi";
			6'h0d: name = "ori";
			6'h0e: name = "xori";
			6'h0f: name = "lui";
			6'h23: name = "lw";
			6'h2b: name = "sw";
			default: name = "nop";
		endcase
	end
	return name;
endfunction

// Runs count instructions from word 0 and records every write
function automatic void runModel(int count);
	logic [31:0] ins, rsV, rtV, sImm, zImm, res, addr;
	logic [4:0] target;
	bit writes;
	for (int i = 0; i < count; i++) begin
		ins = modelMem[i];
		rsV = modelRegs[ins[25:21]];
		rtV = modelRegs[ins[20:16]];
		sImm = {{16{ins[15]}}, ins[15:0]};
		zImm = {16'h0000, ins[15:0]};
		addr = (rsV + sImm) & 32'h0000_01fc; // Word-aligned 9-bit byte address
		target = ins[20:16];
		writes = 1'b1;
		res = '0;
		case (ins[31:26])
			6'h00: begin
				target = ins[15:11];
				case (ins[5:0])
					6'h00: res = rtV << ins[10:6];
					6'h02: res = rtV >> ins[10:6];
					6'h03: res = $signed(rtV) >>> ins[10:6];
					6'h04: res = rtV << rsV[4:0];
					6'h06: res = rtV >> rsV[4:0];
					6'h07: res = $signed(rtV) >>> rsV[4:0];
					6'h20, 6'h21: res = rsV + rtV;
					6'h22, 6'h23: res = rsV - rtV;
					6'h24: res = rsV & rtV;
					6'h25: res = rsV | rtV;
					6'h26: res = rsV ^ rtV;
					6'h27: res = ~(rsV | rtV);
					6'h2a: res = {31'd0, $signed(rsV) < $signed(rtV)};
					6'h2b: res = {31'd0, rsV < rtV};
					default: writes = 1'b0;
				endcase
			end
			6'h08, 6'h09: res = rsV + sImm;
			6'h0a: res = {31'd0, $signed(rsV) < $signed(sImm)};
			6'h0b: res = {31'd0, rsV < sImm};
			6'h0c: res = rsV & zImm;
			6'h0d: res = rsV | zImm;
			6'h0e: res = rsV ^ zImm;
			6'h0f: res = {ins[15:0], 16'h0000};
			6'h23: res = modelMem[addr[8:2]];
			6'h2b: begin
				writes = 1'b0;
				modelMem[addr[8:2]] = rtV;
				expectEvent(1'b1, addr, rtV, mnemonic(ins));
			end
			default: writes = 1'b0;
		endcase
		if (writes) begin
			expectEvent(1'b0, {27'd0, target}, res, mnemonic(ins));
			if (target != 5'd0)
				modelRegs[target] = res;
		end
	end
endfunction

`endif

// ==== test/mipsCoreTb.sv ====
module mipsCoreTb;

	localparam int numRounds = 4;
	localparam int roundLen = 50; // Instructions per program
	localparam int numInstr = numRounds * roundLen;
	localparam int resetCycles = 5;
	localparam int timeoutLimit = numInstr * (5 + 2 * 4) + 100 + numRounds * (resetCycles + 2);

	logic CLK = 1'b0;
	logic reset = 1'b1;
	logic memValid, memWrite;
	logic [8:0] memAddr;
	logic [31:0] memWriteData;
	logic memDone = 1'b0;
	logic [31:0] memReadData = '0;
	logic traceWrite;
	logic [4:0] traceReg;
	logic [31:0] traceData;

	logic [31:0] mem [128];
	int errors = 0;
	int eventsSeen = 0;
	int cycles = 0;
	int waitCnt = 0;
	bit busy = 1'b0;
	logic [8:0] reqAddr = '0;

	logic [5:0] functCodes [16] = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h20, 6'h21,
		6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
	logic [5:0] immOps [8] = '{6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f};

	`include "isaModel.svh"

	mipsCore #(.addrWidth(9)) dut0 (
		.CLK(CLK), .reset(reset),
		.memValid(memValid), .memWrite(memWrite), .memAddr(memAddr),
		.memWriteData(memWriteData), .memDone(memDone), .memReadData(memReadData),
		.traceWrite(traceWrite), .traceReg(traceReg), .traceData(traceData)
	);

	always #5 CLK = ~CLK;

	// Register 0 picked about one time in eight
	function automatic logic [4:0] pickReg();
		logic [31:0] v;
		v = lcgNext();
		return (v[7:5] == 3'd0) ? 5'd0 : v[4:0];
	endfunction

	function automatic logic [31:0] genInstr();
		int choice;
		logic [4:0] rs, rt, rd;
		logic [31:0] r;
		choice = int'(lcgNext() % 32'd26);
		rs = pickReg();
		rt = pickReg();
		rd = pickReg();
		r = lcgNext();
		if (choice < 16)
			return {6'h00, rs, rt, rd, r[4:0], functCodes[choice]};
		if (choice < 24)
			return {immOps[choice-16], rs, rt, r[15:0]};
		// Base r0 and one of 16 data words so loads often hit earlier stores
		return {(choice == 24) ? 6'h23 : 6'h2b, 5'd0, rt, 16'd256 + {10'd0, r[3:0], 2'b00}};
	endfunction

	function automatic void loadProgram();
		for (int w = 0; w < 128; w++) begin
			if (w < roundLen)
				mem[w] = genInstr();
			else if (w < 64)
				mem[w] = {6'h3f, 26'(w)}; // Unknown opcode runs as a no-op
			else
				mem[w] = lcgNext();
			modelMem[w] = mem[w];
		end
		for (int r = 0; r < 32; r++)
			modelRegs[r] = '0;
		runModel(roundLen);
	endfunction

	task automatic checkEvent(input bit kind, input logic [31:0] a, input logic [31:0] d);
		bit k;
		logic [31:0] ea, ed;
		string name;
		if (expKind.size() == 0) begin
			errors++;
			$display("Core made a %s that the model did not predict",
				kind ? "store" : "register write");
			return;
		end
		k = expKind.pop_front();
		ea = expAddr.pop_front();
		ed = expData.pop_front();
		name = expName.pop_front();
		assert (k == kind) else begin
			errors++;
			$display("error %s kind: expected %0d, actual %0d", name, k, kind);
		end
		assert (ea == a) else begin
			errors++;
			$display("error %s target: expected %h, actual %h", name, ea, a);
		end
		assert (ed == d) else begin
			errors++;
			$display("error %s data: expected %h, actual %h", name, ed, d);
		end
		eventsSeen++;
	endtask

	// Memory with 0 to 3 cycles of random delay
	always @(posedge CLK) begin
		if (reset) begin
			memDone <= 1'b0;
			busy <= 1'b0;
			waitCnt <= 0;
		end else begin
			memDone <= 1'b0;
			assert (!(busy && !memValid)) else begin
				errors++;
				$display("memValid dropped before memDone");
			end
			if (memValid && !memDone) begin
				if (busy) begin
					assert (memAddr == reqAddr) else begin
						errors++;
						$display("error addrStable: expected %h, actual %h", reqAddr, memAddr);
					end
				end
				if (waitCnt == 0) begin
					memDone <= 1'b1;
					busy <= 1'b0;
					memReadData <= mem[memAddr[8:2]];
					if (memWrite) begin
						mem[memAddr[8:2]] = memWriteData;
						checkEvent(1'b1, {23'd0, memAddr}, memWriteData);
					end
					waitCnt <= int'(lcgNext() % 32'd4);
				end else begin
					busy <= 1'b1;
					reqAddr <= memAddr;
					waitCnt <= waitCnt - 1;
				end
			end
		end
	end

	always @(posedge CLK) begin
		if (!reset && traceWrite)
			checkEvent(1'b0, {27'd0, traceReg}, traceData);
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= timeoutLimit) begin
			$display("Timeout after %0d cycles, the core did not finish the program", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial begin
		for (int round = 0; round < numRounds; round++) begin
			@(posedge CLK);
			reset <= 1'b1;
			@(posedge CLK);
			loadProgram();
			repeat (resetCycles - 1) @(posedge CLK);
			reset <= 1'b0;
			while (eventsSeen < (round + 1) * roundLen)
				@(posedge CLK);
		end
		repeat (4) @(posedge CLK);
		if (expKind.size() != 0) begin
			errors++;
			$display("Model still holds %0d events the core never made", expKind.size());
		end
		$display("Checked %0d events, %0d errors", eventsSeen, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== hw/mipsCore.sv ====
module mipsCore #(
	parameter int addrWidth = 9
) (
	input logic CLK,
	input logic reset,
	output logic memValid,
	output logic memWrite,
	output logic [addrWidth-1:0] memAddr,
	output logic [mipsPkg::dataWidth-1:0] memWriteData,
	input logic memDone,
	input logic [mipsPkg::dataWidth-1:0] memReadData,
	output logic traceWrite,
	output logic [mipsPkg::regAddrWidth-1:0] traceReg,
	output logic [mipsPkg::dataWidth-1:0] traceData
);
	import mipsPkg::*;

	logic irLoad, pcLoad, marFromAlu, mdrLoad, regWrite;
	regDstE regDst;
	regInE regIn;
	aluSrcE aluSrc;
	aluOpE aluOp;
	opcodeE opcode;
	functE funct;

	controlUnit #(.addrWidth(addrWidth)) cu0 (
		.CLK(CLK), .reset(reset),
		.opcode(opcode), .funct(funct),
		.memDone(memDone),
		.memValid(memValid), .memWrite(memWrite),
		.irLoad(irLoad), .pcLoad(pcLoad), .marFromAlu(marFromAlu),
		.mdrLoad(mdrLoad), .regWrite(regWrite),
		.regDst(regDst), .regIn(regIn), .aluSrc(aluSrc), .aluOp(aluOp)
	);

	datapath #(.addrWidth(addrWidth)) dp0 (
		.CLK(CLK), .reset(reset),
		.irLoad(irLoad), .pcLoad(pcLoad), .marFromAlu(marFromAlu),
		.mdrLoad(mdrLoad), .regWrite(regWrite),
		.regDst(regDst), .regIn(regIn), .aluSrc(aluSrc), .aluOp(aluOp),
		.opcode(opcode), .funct(funct),
		.memAddr(memAddr), .memWriteData(memWriteData), .memReadData(memReadData),
		.traceWrite(traceWrite), .traceReg(traceReg), .traceData(traceData)
	);

endmodule

// ==== hw/datapath.sv ====
module datapath #(
	parameter int addrWidth = 9
) (
	input logic CLK,
	input logic reset,
	input logic irLoad,
	input logic pcLoad,
	input logic marFromAlu,
	input logic mdrLoad,
	input logic regWrite,
	input mipsPkg::regDstE regDst,
	input mipsPkg::regInE regIn,
	input mipsPkg::aluSrcE aluSrc,
	input mipsPkg::aluOpE aluOp,
	output mipsPkg::opcodeE opcode,
	output mipsPkg::functE funct,
	output logic [addrWidth-1:0] memAddr,
	output logic [mipsPkg::dataWidth-1:0] memWriteData,
	input logic [mipsPkg::dataWidth-1:0] memReadData,
	output logic traceWrite,
	output logic [mipsPkg::regAddrWidth-1:0] traceReg,
	output logic [mipsPkg::dataWidth-1:0] traceData
);
	import mipsPkg::*;

	logic [addrWidth-1:0] pc, mar;
	logic [dataWidth-1:0] ir, mdr;
	logic [regAddrWidth-1:0] rs, rt, rd, writeReg;
	logic [4:0] sa;
	logic [dataWidth-1:0] rsData, rtData;
	logic [dataWidth-1:0] signImm, zeroImm;
	logic [dataWidth-1:0] operandA, operandB, aluResult, writeData;

	// Instruction fields
	assign opcode = opcodeE'(ir[31:26]);
	assign funct = functE'(ir[5:0]);
	assign rs = ir[25:21];
	assign rt = ir[20:16];
	assign rd = ir[15:11];
	assign sa = ir[10:6];
	assign signImm = {{(dataWidth-16){ir[15]}}, ir[15:0]};
	assign zeroImm = {{(dataWidth-16){1'b0}}, ir[15:0]};

	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= '0;
			mar <= '0;
		end else begin
			if (pcLoad)
				pc <= pc + addrWidth'(4);
			if (marFromAlu)
				mar <= {aluResult[addrWidth-1:2], 2'b00}; // Byte offset dropped
			else
				mar <= pc;
		end
	end

	always_ff @(posedge CLK) begin
		if (irLoad)
			ir <= memReadData;
		if (mdrLoad)
			mdr <= (regIn == inMem) ? memReadData : rtData; // Load data or store data
	end

	assign memAddr = mar;
	assign memWriteData = mdr;

	// Shifts by sa take the amount on operand A
	assign operandA = (aluSrc == srcShamt) ? {{(dataWidth-5){1'b0}}, sa} : rsData;

	always_comb begin
		case (aluSrc)
			srcSignImm: operandB = signImm;
			srcZeroImm: operandB = zeroImm;
			default: operandB = rtData; // Register and shift forms
		endcase
	end

	assign writeReg = (regDst == dstRt) ? rt : rd;
	assign writeData = (regIn == inMem) ? mdr : aluResult;

	registerFile rf0 (
		.CLK(CLK), .reset(reset),
		.readRegA(rs), .readRegB(rt),
		.writeEnable(regWrite), .writeReg(writeReg), .writeData(writeData),
		.readDataA(rsData), .readDataB(rtData)
	);

	alu alu0 (
		.aluOp(aluOp),
		.operandA(operandA),
		.operandB(operandB),
		.result(aluResult)
	);

	// Every register-file write shows on the trace
	assign traceWrite = regWrite;
	assign traceReg = writeReg;
	assign traceData = writeData;

endmodule

// ==== hw/controlUnit.sv ====
module controlUnit #(
	parameter int addrWidth = 9
) (
	input logic CLK,
	input logic reset,
	input mipsPkg::opcodeE opcode,
	input mipsPkg::functE funct,
	input logic memDone,
	output logic memValid,
	output logic memWrite,
	output logic irLoad,
	output logic pcLoad,
	output logic marFromAlu,
	output logic mdrLoad,
	output logic regWrite,
	output mipsPkg::regDstE regDst,
	output mipsPkg::regInE regIn,
	output mipsPkg::aluSrcE aluSrc,
	output mipsPkg::aluOpE aluOp
);
	import mipsPkg::*;

	stateE state, nextState;
	logic isAlu, isLoad, isStore;
	logic memAck; // Transaction completes at this edge
	logic memGap; // Forces one idle cycle between transactions

	// Word addressing needs bits above the byte offset
	if (addrWidth < 3) begin : gWidthCheck
		$error("addrWidth too small for word addressing");
	end

	// Instruction decode stays constant for the whole instruction
	always_comb begin
		aluOp = aluAdd;
		aluSrc = srcSignImm;
		regDst = dstRt;
		regIn = inAlu;
		isAlu = 1'b1;
		isLoad = 1'b0;
		isStore = 1'b0;
		case (opcode)
			opSpecial: begin
				regDst = dstRd;
				aluSrc = (funct inside {fnSll, fnSrl, fnSra}) ? srcShamt : srcReg;
				case (funct)
					fnAdd, fnAddu: aluOp = aluAdd;
					fnSub, fnSubu: aluOp = aluSub;
					fnAnd: aluOp = aluAnd;
					fnOr: aluOp = aluOr;
					fnNor: aluOp = aluNor;
					fnXor: aluOp = aluXor;
					fnSlt: aluOp = aluSlt;
					fnSltu: aluOp = aluSltu;
					fnSll, fnSllv: aluOp = aluSll;
					fnSrl, fnSrlv: aluOp = aluSrl;
					fnSra, fnSrav: aluOp = aluSra;
					default: isAlu = 1'b0; // Unknown funct runs as a no-op
				endcase
			end
			opAddi, opAddiu: aluOp = aluAdd;
			opSlti: aluOp = aluSlt;
			opSltiu: aluOp = aluSltu; // Sign-extended immediate compared unsigned
			opAndi: begin
				aluOp = aluAnd;
				aluSrc = srcZeroImm;
			end
			opOri: begin
				aluOp = aluOr;
				aluSrc = srcZeroImm;
			end
			opXori: begin
				aluOp = aluXor;
				aluSrc = srcZeroImm;
			end
			opLui: aluOp = aluLui;
			opLw: begin
				isAlu = 1'b0;
				isLoad = 1'b1;
				regIn = inMem;
			end
			opSw: begin
				isAlu = 1'b0;
				isStore = 1'b1;
			end
			default: isAlu = 1'b0;
		endcase
	end

	always_comb begin
		nextState = state;
		case (state)
			stIdle: nextState = stFetch;
			stFetch: if (memAck) nextState = stDecode;
			stDecode: nextState = stExecute;
			stExecute: begin
				if (isLoad)
					nextState = stMemRead;
				else if (isStore)
					nextState = stMemWrite;
				else if (isAlu)
					nextState = stWriteBack;
				else
					nextState = stFetch;
			end
			stWriteBack: nextState = stFetch;
			stMemRead: if (memAck) nextState = stWriteBack;
			stMemWrite: if (memAck) nextState = stFetch;
			default: nextState = stIdle;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= stIdle;
			memGap <= 1'b0;
		end else begin
			state <= nextState;
			memGap <= memAck;
		end
	end

	assign memValid = (state inside {stFetch, stMemRead, stMemWrite}) && !memGap;
	assign memWrite = (state == stMemWrite);
	assign memAck = memValid && memDone;

	assign irLoad = (state == stFetch) && memAck;
	assign pcLoad = (state == stFetch) && memAck;
	// Data address held until the access ends, then MAR follows the PC again
	assign marFromAlu = (isLoad || isStore) && ((state == stExecute) ||
		((state inside {stMemRead, stMemWrite}) && !memAck));
	assign mdrLoad = ((state == stExecute) && isStore) || ((state == stMemRead) && memAck);
	assign regWrite = (state == stWriteBack);

	memWriteHeld: assert property (@(posedge CLK) disable iff (reset)
		memValid && !memDone |=> $stable(memWrite));

	// Transactions start in fetch or right after execute
	noEarlyValid: assert property (@(posedge CLK) disable iff (reset)
		$rose(memValid) |-> (state == stFetch) || ($past(state) == stExecute));

endmodule

// ==== hw/registerFile.sv ====
module registerFile (
	input logic CLK,
	input logic reset,
	input logic [mipsPkg::regAddrWidth-1:0] readRegA,
	input logic [mipsPkg::regAddrWidth-1:0] readRegB,
	input logic writeEnable,
	input logic [mipsPkg::regAddrWidth-1:0] writeReg,
	input logic [mipsPkg::dataWidth-1:0] writeData,
	output logic [mipsPkg::dataWidth-1:0] readDataA,
	output logic [mipsPkg::dataWidth-1:0] readDataB
);
	import mipsPkg::*;

	localparam int numRegs = 2 ** regAddrWidth;

	logic [dataWidth-1:0] regs [numRegs];

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < numRegs; i++)
				regs[i] <= '0;
		end else if (writeEnable && writeReg != '0) begin
			regs[writeReg] <= writeData; // r0 stays zero
		end
	end

	assign readDataA = regs[readRegA];
	assign readDataB = regs[readRegB];

	// r0 is never written even when the trace shows a write
	zeroReg: assert property (@(posedge CLK) disable iff (reset)
		readRegA == '0 |-> readDataA == '0);

endmodule

// ==== hw/alu.sv ====
module alu (
	input mipsPkg::aluOpE aluOp,
	input logic [mipsPkg::dataWidth-1:0] operandA,
	input logic [mipsPkg::dataWidth-1:0] operandB,
	output logic [mipsPkg::dataWidth-1:0] result
);
	import mipsPkg::*;

	logic [4:0] shamt;
	logic lessSigned, lessUnsigned;

	assign shamt = operandA[4:0]; // Amount from rs or sa
	assign lessSigned = $signed(operandA) < $signed(operandB);
	assign lessUnsigned = operandA < operandB;

	always_comb begin
		case (aluOp)
			aluAdd: result = operandA + operandB; // Wraps without overflow trap
			aluSub: result = operandA - operandB;
			aluAnd: result = operandA & operandB;
			aluOr: result = operandA | operandB;
			aluNor: result = ~(operandA | operandB);
			aluXor: result = operandA ^ operandB;
			aluSlt: result = {{(dataWidth-1){1'b0}}, lessSigned};
			aluSltu: result = {{(dataWidth-1){1'b0}}, lessUnsigned};
			aluSll: result = operandB << shamt;
			aluSrl: result = operandB >> shamt;
			aluSra: result = $signed(operandB) >>> shamt; // Sign fill
			aluLui: result = operandB << 16;
			default: result = '0;
		endcase
	end

endmodule

// ==== hw/mipsPkg.sv ====
package mipsPkg;

	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;

	// Primary opcodes of the supported subset
	typedef enum logic [5:0] {
		opSpecial = 6'h00,
		opAddi    = 6'h08,
		opAddiu   = 6'h09,
		opSlti    = 6'h0a,
		opSltiu   = 6'h0b,
		opAndi    = 6'h0c,
		opOri     = 6'h0d,
		opXori    = 6'h0e,
		opLui     = 6'h0f,
		opLw      = 6'h23,
		opSw      = 6'h2b
	} opcodeE;

	// R-type funct field
	typedef enum logic [5:0] {
		fnSll  = 6'h00,
		fnSrl  = 6'h02,
		fnSra  = 6'h03,
		fnSllv = 6'h04,
		fnSrlv = 6'h06,
		fnSrav = 6'h07,
		fnAdd  = 6'h20,
		fnAddu = 6'h21,
		fnSub  = 6'h22,
		fnSubu = 6'h23,
		fnAnd  = 6'h24,
		fnOr   = 6'h25,
		fnXor  = 6'h26,
		fnNor  = 6'h27,
		fnSlt  = 6'h2a,
		fnSltu = 6'h2b
	} functE;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluNor, aluXor,
		aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
	} aluOpE;

	typedef enum logic [3:0] {
		stIdle, stFetch, stDecode, stExecute, stWriteBack, stMemRead, stMemWrite
	} stateE;

	typedef enum logic {dstRd, dstRt} regDstE; // Destination field
	typedef enum logic {inAlu, inMem} regInE; // Writeback source

	// Operand B source; srcShamt also puts sa on operand A
	typedef enum logic [1:0] {
		srcReg, srcSignImm, srcZeroImm, srcShamt
	} aluSrcE;

endpackage
